// File: compile.f
breakout_pkg.sv
brick_map.sv
brick_arbiter.sv
ball_control.sv
ball_logic.sv
breakout_core.sv
tb_clock.sv
breakout_tb.sv

// File: Makefile
TOP := breakout_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir

// File: breakout_tb.sv
module breakout_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import breakout_pkg::*;

	localparam int field_w     = 128;
	localparam int field_h     = 128;
	localparam int ball_size   = 4;
	localparam int brick_w     = 8;
	localparam int brick_h     = 8;
	localparam int queue_depth = 2;
	localparam int num_reads   = 1200;
	// wall, paddle, bricks and contention runs
	localparam int total_steps = 200 + 150 + 200 + 200;
	localparam int load_cycles = 128 + (6 * 128 + num_reads) * 2;
	localparam int max_cycles  = total_steps * 40 + load_cycles;

	logic       clk;
	logic       resetn;
	logic       step;
	coord_t     start_x;
	coord_t     start_y;
	coord_t     plat_x;
	coord_t     plat_y;
	coord_t     plat_w;
	logic       host_req_valid;
	logic       host_req_write;
	cell_addr_t host_req_addr;
	hp_t        host_req_hp;
	logic       host_credit;
	logic       host_rsp_valid;
	hp_t        host_rsp_hp;
	coord_t     ball_x;
	coord_t     ball_y;
	logic       x_dir;
	logic       y_dir;
	logic       collision;
	logic       miss;
	logic       step_done;

	// shadow of the brick map and recent ball hits per cell
	int shadow [128];
	int before_hp [128];
	int hit_step [128];
	int rd_addr_log [2048];
	int rd_issued;
	int step_no;
	bit ball_running;

	// expected ball after the step in flight
	int model_x;
	int model_y;
	bit model_xd;
	bit model_yd;
	int exp_hits;
	bit exp_miss;

	// owned by the compare process
	int host_credits = queue_depth;
	int rd_seen = 0;
	int coll_cnt = 0;
	int miss_cnt = 0;
	int err_ball = 0;
	int err_host = 0;
	int err_credit = 0;
	int err_flow;
	int cycles = 0;

	tb_clock clock_gen (
		.clk    (clk),
		.resetn (resetn)
	);

	breakout_core #(
		.field_w     (field_w),
		.field_h     (field_h),
		.ball_size   (ball_size),
		.brick_w     (brick_w),
		.brick_h     (brick_h),
		.queue_depth (queue_depth)
	) uut (
		.clk            (clk),
		.resetn         (resetn),
		.step           (step),
		.start_x        (start_x),
		.start_y        (start_y),
		.plat_x         (plat_x),
		.plat_y         (plat_y),
		.plat_w         (plat_w),
		.host_req_valid (host_req_valid),
		.host_req_write (host_req_write),
		.host_req_addr  (host_req_addr),
		.host_req_hp    (host_req_hp),
		.host_credit    (host_credit),
		.host_rsp_valid (host_rsp_valid),
		.host_rsp_hp    (host_rsp_hp),
		.ball_x         (ball_x),
		.ball_y         (ball_y),
		.x_dir          (x_dir),
		.y_dir          (y_dir),
		.collision      (collision),
		.miss           (miss),
		.step_done      (step_done)
	);

	// row times 16 plus column
	function automatic int cell_of(input int px, input int py);
		return (py / brick_h) * 16 + px / brick_w;
	endfunction

	// bricks fill the top 64 rows of the field
	function automatic bit brick_here(input int px, input int py);
		if (px < 0 || px >= 16 * brick_w || py < 0 || py >= 8 * brick_h)
			return 1'b0;
		return shadow[cell_of(px, py)] != 0;
	endfunction

	// keep the value from before the latest run of hits
	function automatic void note_hit(input int a);
		if (hit_step[a] + 2 < step_no)
			before_hp[a] = shadow[a];
		hit_step[a] = step_no;
		shadow[a] = shadow[a] - 1;
	endfunction

	// one frame step of the ball through probes, walls, paddle and move
	function automatic void predict_step(inout int x, inout int y, inout bit xd, inout bit yd,
			input int pad_x, input int pad_y, input int pad_w,
			output int hits, output bit missed);
		int px;
		int py;
		hits = 0;
		missed = 1'b0;
		px = xd ? x + ball_size : x - 1;
		py = y;
		if (brick_here(px, py)) begin
			note_hit(cell_of(px, py));
			xd = !xd;
			hits++;
		end
		// vertical probe sees the horizontal result
		px = x;
		py = yd ? y + ball_size : y - 1;
		if (brick_here(px, py)) begin
			note_hit(cell_of(px, py));
			yd = !yd;
			hits++;
		end
		if (x == 0)
			xd = 1'b1;
		else if (x == field_w - ball_size)
			xd = 1'b0;
		if (y == 0)
			yd = 1'b1;
		if (yd && y + ball_size == pad_y && x + ball_size > pad_x && x < pad_x + pad_w)
			yd = 1'b0;
		if (y == field_h - ball_size) begin
			yd = 1'b0;
			missed = 1'b1;
		end
		x = xd ? x + 1 : x - 1;
		y = yd ? y + 1 : y - 1;
	endfunction

	// while the ball runs a read may still see a cell before its decrement
	function automatic bit read_ok(input int a, input int v);
		if (v == shadow[a])
			return 1'b1;
		return ball_running && (hit_step[a] + 2 >= step_no) &&
			v > shadow[a] && v <= before_hp[a];
	endfunction

	function automatic void print_error_counts();
		$display("errors: ball %0d, host %0d, credit %0d, flow %0d",
			err_ball, err_host, err_credit, err_flow);
	endfunction

	task automatic host_request(input bit wr, input int a, input int hp);
		// only with a credit in hand
		while (host_credits <= 0) begin
			@(posedge clk);
			#5;
		end
		if (!wr) begin
			rd_addr_log[rd_issued] = a;
			rd_issued++;
		end
		host_req_valid = 1'b1;
		host_req_write = wr;
		host_req_addr  = cell_addr_t'(a);
		host_req_hp    = hp_t'(hp);
		@(posedge clk);
		#5;
		host_req_valid = 1'b0;
	endtask

	// every host entry popped and the last read given its one cycle to land
	task automatic drain_host();
		while (host_credits != queue_depth) begin
			@(posedge clk);
			#5;
		end
		repeat (2) begin
			@(posedge clk);
			#5;
		end
		assert (rd_seen == rd_issued) else begin
			$display("host reads lost, %0d issued but %0d answered", rd_issued, rd_seen);
			err_flow++;
		end
	endtask

	task automatic load_map(input bit fill);
		int hp;
		for (int a = 0; a < 128; a++) begin
			hp = fill ? int'($urandom_range(3, 0)) : 0;
			shadow[a] = hp;
			host_request(1'b1, a, hp);
		end
		drain_host();
	endtask

	task automatic read_all();
		for (int a = 0; a < 128; a++)
			host_request(1'b0, a, 0);
		drain_host();
	endtask

	task automatic run_steps(input int n);
		for (int i = 0; i < n; i++) begin
			step_no++;
			predict_step(model_x, model_y, model_xd, model_yd, int'(plat_x), int'(plat_y),
				int'(plat_w), exp_hits, exp_miss);
			step = 1'b1;
			@(posedge clk);
			#5;
			step = 1'b0;
			while (!step_done) begin
				@(posedge clk);
				#5;
			end
			// compare happens on the falling edge of this cycle
			@(posedge clk);
			#5;
		end
	endtask

	// credits, host responses and ball results checked mid cycle
	always @(negedge clk) begin
		int nc;
		int a;
		if (resetn) begin
			nc = host_credits - int'(host_req_valid) + int'(host_credit);
			assert (nc >= 0 && nc <= queue_depth) else begin
				$display("ERR %0t: host credit count %0d out of range", $time, nc);
				err_credit++;
			end
			host_credits = nc;
			if (host_rsp_valid) begin
				if (rd_seen < rd_issued) begin
					a = rd_addr_log[rd_seen];
					rd_seen++;
					assert (read_ok(a, int'(host_rsp_hp))) else begin
						$display("ERR %0t: cell %0d read %0d, expected %0d", $time, a,
							host_rsp_hp, shadow[a]);
						err_host++;
					end
				end else begin
					$display("ERR %0t: host response with no read outstanding", $time);
					err_host++;
				end
			end
			if (collision)
				coll_cnt++;
			if (miss)
				miss_cnt++;
			if (step_done) begin
				assert (int'(ball_x) == model_x && int'(ball_y) == model_y &&
						x_dir == model_xd && y_dir == model_yd) else begin
					$display("ERR %0t: step %0d ball (%0d,%0d) dir %b%b, expected (%0d,%0d) %b%b",
						$time, step_no, ball_x, ball_y, x_dir, y_dir, model_x, model_y,
						model_xd, model_yd);
					err_ball++;
				end
				assert (coll_cnt == exp_hits && miss == exp_miss) else begin
					$display("ERR %0t: step %0d hits %0d miss %b, expected %0d %b", $time,
						step_no, coll_cnt, miss, exp_hits, exp_miss);
					err_ball++;
				end
				coll_cnt = 0;
			end
		end
	end

	// hard limit on the whole run
	always @(posedge clk) begin
		cycles++;
		if (cycles > max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			print_error_counts();
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int m0;
		void'($urandom(32'h99af_41a3));
		step = 1'b0;
		start_x = coord_t'(100);
		start_y = coord_t'(70);
		// no paddle for the wall run
		plat_x = '0;
		plat_y = '0;
		plat_w = '0;
		host_req_valid = 1'b0;
		host_req_write = 1'b0;
		host_req_addr = '0;
		host_req_hp = '0;
		rd_issued = 0;
		step_no = 0;
		ball_running = 1'b0;
		model_x = 100;
		model_y = 70;
		model_xd = 1'b1;
		model_yd = 1'b1;
		exp_hits = 0;
		exp_miss = 1'b0;
		err_flow = 0;
		for (int i = 0; i < 128; i++) begin
			shadow[i] = 0;
			before_hp[i] = 0;
			hit_step[i] = -100;
		end
		wait (resetn === 1'b1);
		assert (int'(ball_x) == 100 && int'(ball_y) == 70 && x_dir && y_dir) else begin
			$display("ERR %0t: ball not at its start position after reset", $time);
			err_flow++;
		end
		// let the clear sweep run out
		repeat (130) begin
			@(posedge clk);
			#5;
		end
		// load and readback
		load_map(1'b1);
		read_all();
		// walls on an empty field
		load_map(1'b0);
		run_steps(200);
		// full width paddle across the path
		plat_x = coord_t'(0);
		plat_y = coord_t'(100);
		plat_w = coord_t'(128);
		m0 = miss_cnt;
		run_steps(150);
		assert (miss_cnt == m0) else begin
			$display("ball missed %0d times with the paddle in place", miss_cnt - m0);
			err_flow++;
		end
		// brick hits and then a compare of the whole map
		load_map(1'b1);
		run_steps(200);
		read_all();
		// host reads back to back while the ball runs
		ball_running = 1'b1;
		fork
			run_steps(200);
			for (int i = 0; i < num_reads; i++)
				host_request(1'b0, int'($urandom_range(127, 0)), 0);
		join
		drain_host();
		repeat (4) begin
			@(posedge clk);
			#5;
		end
		ball_running = 1'b0;
		read_all();
		print_error_counts();
		if (err_ball + err_host + err_credit + err_flow == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb_clock.sv
module tb_clock #(
	parameter int half_period  = 20,
	parameter int reset_cycles = 5
) (
	output logic clk,
	output logic resetn
);
	timeunit 1ns;
	timeprecision 100ps;

	// free running, 40 ns period
	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// release a little after the edge like every other input
	initial begin
		resetn = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#5;
		resetn = 1'b1;
	end

endmodule

// File: breakout_core.sv
module breakout_core #(
	parameter int unsigned field_w     = 128,
	parameter int unsigned field_h     = 128,
	parameter int unsigned ball_size   = 4,
	parameter int unsigned brick_w     = 8,
	parameter int unsigned brick_h     = 8,
	parameter int unsigned queue_depth = 2
) (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     step,
	input  breakout_pkg::coord_t     start_x,
	input  breakout_pkg::coord_t     start_y,
	input  breakout_pkg::coord_t     plat_x,
	input  breakout_pkg::coord_t     plat_y,
	input  breakout_pkg::coord_t     plat_w,
	// host port into the brick map
	input  logic                     host_req_valid,
	input  logic                     host_req_write,
	input  breakout_pkg::cell_addr_t host_req_addr,
	input  breakout_pkg::hp_t        host_req_hp,
	output logic                     host_credit,
	output logic                     host_rsp_valid,
	output breakout_pkg::hp_t        host_rsp_hp,
	// ball
	output breakout_pkg::coord_t     ball_x,
	output breakout_pkg::coord_t     ball_y,
	output logic                     x_dir,
	output logic                     y_dir,
	output logic                     collision,
	output logic                     miss,
	output logic                     step_done
);
	import breakout_pkg::*;

	// control to ball logic
	logic probe_h;
	logic probe_v;
	logic do_move;
	logic probe_done;

	// ball request port
	logic       ball_req_valid;
	logic       ball_req_write;
	cell_addr_t ball_req_addr;
	hp_t        ball_req_hp;
	logic       ball_credit;
	logic       ball_rsp_valid;
	hp_t        ball_rsp_hp;

	// memory side
	logic       mem_en;
	logic       mem_write;
	cell_addr_t mem_addr;
	hp_t        mem_wdata;
	hp_t        mem_rdata;
	logic       mem_ready;

	ball_control u_control (
		.clk        (clk),
		.resetn     (resetn),
		.step       (step),
		.probe_done (probe_done),
		.probe_h    (probe_h),
		.probe_v    (probe_v),
		.do_move    (do_move),
		.step_done  (step_done)
	);

	ball_logic #(
		.field_w     (field_w),
		.field_h     (field_h),
		.ball_size   (ball_size),
		.brick_w     (brick_w),
		.brick_h     (brick_h),
		.queue_depth (queue_depth)
	) u_ball (
		.clk        (clk),
		.resetn     (resetn),
		.start_x    (start_x),
		.start_y    (start_y),
		.plat_x     (plat_x),
		.plat_y     (plat_y),
		.plat_w     (plat_w),
		.probe_h    (probe_h),
		.probe_v    (probe_v),
		.do_move    (do_move),
		.probe_done (probe_done),
		.req_valid  (ball_req_valid),
		.req_write  (ball_req_write),
		.req_addr   (ball_req_addr),
		.req_hp     (ball_req_hp),
		.credit     (ball_credit),
		.rsp_valid  (ball_rsp_valid),
		.rsp_hp     (ball_rsp_hp),
		.ball_x     (ball_x),
		.ball_y     (ball_y),
		.x_dir      (x_dir),
		.y_dir      (y_dir),
		.collision  (collision),
		.miss       (miss)
	);

	brick_arbiter #(
		.queue_depth (queue_depth)
	) u_arbiter (
		.clk            (clk),
		.resetn         (resetn),
		.ball_req_valid (ball_req_valid),
		.ball_req_write (ball_req_write),
		.ball_req_addr  (ball_req_addr),
		.ball_req_hp    (ball_req_hp),
		.ball_credit    (ball_credit),
		.ball_rsp_valid (ball_rsp_valid),
		.ball_rsp_hp    (ball_rsp_hp),
		.host_req_valid (host_req_valid),
		.host_req_write (host_req_write),
		.host_req_addr  (host_req_addr),
		.host_req_hp    (host_req_hp),
		.host_credit    (host_credit),
		.host_rsp_valid (host_rsp_valid),
		.host_rsp_hp    (host_rsp_hp),
		.mem_en         (mem_en),
		.mem_write      (mem_write),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_rdata      (mem_rdata),
		.mem_ready      (mem_ready)
	);

	brick_map u_map (
		.clk    (clk),
		.resetn (resetn),
		.en     (mem_en),
		.write  (mem_write),
		.addr   (mem_addr),
		.wdata  (mem_wdata),
		.rdata  (mem_rdata),
		.ready  (mem_ready)
	);

endmodule

// File: ball_logic.sv
module ball_logic #(
	parameter int unsigned field_w     = 128,
	parameter int unsigned field_h     = 128,
	parameter int unsigned ball_size   = 4,
	parameter int unsigned brick_w     = 8,
	parameter int unsigned brick_h     = 8,
	parameter int unsigned queue_depth = 2
) (
	input  logic                     clk,
	input  logic                     resetn,
	input  breakout_pkg::coord_t     start_x,
	input  breakout_pkg::coord_t     start_y,
	input  breakout_pkg::coord_t     plat_x,
	input  breakout_pkg::coord_t     plat_y,
	input  breakout_pkg::coord_t     plat_w,
	input  logic                     probe_h,
	input  logic                     probe_v,
	input  logic                     do_move,
	output logic                     probe_done,
	// brick request port
	output logic                     req_valid,
	output logic                     req_write,
	output breakout_pkg::cell_addr_t req_addr,
	output breakout_pkg::hp_t        req_hp,
	input  logic                     credit,
	input  logic                     rsp_valid,
	input  breakout_pkg::hp_t        rsp_hp,
	// ball state
	output breakout_pkg::coord_t     ball_x,
	output breakout_pkg::coord_t     ball_y,
	output logic                     x_dir,
	output logic                     y_dir,
	output logic                     collision,
	output logic                     miss
);
	import breakout_pkg::*;

	// 16 by 8 brick grid
	localparam int unsigned grid_cols = 16;
	localparam int unsigned grid_rows = 8;
	localparam int unsigned col_shift = $clog2(brick_w);
	localparam int unsigned row_shift = $clog2(brick_h);
	localparam int unsigned cnt_w     = $clog2(queue_depth + 1);

	coord_t     probe_px;
	coord_t     probe_py;
	logic       in_area;
	cell_addr_t probe_addr;

	// request bookkeeping
	logic             pend_rd;
	logic             pend_wr;
	logic             wait_rsp;
	logic             probe_axis;
	cell_addr_t       rd_addr;
	cell_addr_t       wr_addr;
	hp_t              wr_hp;
	logic [cnt_w-1:0] credits;
	logic             send;

	// bounce results for the move
	logic nx_dir;
	logic ny_dir;
	logic hit_bottom;

	// pixel just past the leading edge
	// x_dir 1 is right, y_dir 1 is down
	always_comb begin
		if (probe_v) begin
			probe_px = ball_x;
			probe_py = y_dir ? ball_y + coord_t'(ball_size) : ball_y - 1'b1;
		end else begin
			probe_px = x_dir ? ball_x + coord_t'(ball_size) : ball_x - 1'b1;
			probe_py = ball_y;
		end
	end

	// x - 1 at the left wall wraps high and lands outside too
	assign in_area = (probe_px < coord_t'(grid_cols * brick_w)) &&
		(probe_py < coord_t'(grid_rows * brick_h));
	assign probe_addr = cell_addr_t'((probe_py >> row_shift) * grid_cols +
		(probe_px >> col_shift));

	// pending write goes first so it stays ahead of the next read
	assign send      = (pend_wr || pend_rd) && (credits != '0);
	assign req_valid = send;
	assign req_write = pend_wr;
	assign req_addr  = pend_wr ? wr_addr : rd_addr;
	assign req_hp    = wr_hp;

	// walls, paddle and floor, later rules win
	always_comb begin
		nx_dir     = x_dir;
		ny_dir     = y_dir;
		hit_bottom = 1'b0;
		if (ball_x == '0)
			nx_dir = 1'b1;
		else if (ball_x == coord_t'(field_w - ball_size))
			nx_dir = 1'b0;
		if (ball_y == '0)
			ny_dir = 1'b1;
		// paddle top edge, only when coming down
		if (y_dir && (ball_y + coord_t'(ball_size) == plat_y) &&
				(ball_x + coord_t'(ball_size) > plat_x) && (ball_x < plat_x + plat_w))
			ny_dir = 1'b0;
		if (ball_y == coord_t'(field_h - ball_size)) begin
			ny_dir     = 1'b0;
			hit_bottom = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pend_rd    <= 1'b0;
			pend_wr    <= 1'b0;
			wait_rsp   <= 1'b0;
			probe_axis <= 1'b0;
			probe_done <= 1'b0;
			collision  <= 1'b0;
			miss       <= 1'b0;
			credits    <= cnt_w'(queue_depth);
			ball_x     <= start_x;
			ball_y     <= start_y;
			x_dir      <= 1'b1;
			y_dir      <= 1'b1;
		end else begin
			probe_done <= 1'b0;
			collision  <= 1'b0;
			miss       <= 1'b0;
			credits    <= credits - cnt_w'(send) + cnt_w'(credit);
			if (send) begin
				if (pend_wr) begin
					pend_wr <= 1'b0;
				end else begin
					pend_rd  <= 1'b0;
					wait_rsp <= 1'b1;
				end
			end
			// new probe, off the grid it is done at once
			if (probe_h || probe_v) begin
				probe_axis <= probe_v;
				if (in_area)
					pend_rd <= 1'b1;
				else
					probe_done <= 1'b1;
			end
			if (wait_rsp && rsp_valid) begin
				wait_rsp   <= 1'b0;
				probe_done <= 1'b1;
				// brick hit
				if (rsp_hp != '0) begin
					pend_wr   <= 1'b1;
					collision <= 1'b1;
					if (probe_axis)
						y_dir <= ~y_dir;
					else
						x_dir <= ~x_dir;
				end
			end
			if (do_move) begin
				x_dir  <= nx_dir;
				y_dir  <= ny_dir;
				miss   <= hit_bottom;
				ball_x <= nx_dir ? ball_x + 1'b1 : ball_x - 1'b1;
				ball_y <= ny_dir ? ball_y + 1'b1 : ball_y - 1'b1;
			end
		end
	end

	// addresses and write data
	always_ff @(posedge clk) begin
		if ((probe_h || probe_v) && in_area)
			rd_addr <= probe_addr;
		if (wait_rsp && rsp_valid) begin
			wr_addr <= rd_addr;
			wr_hp   <= rsp_hp - 1'b1;
		end
	end

endmodule

// File: ball_control.sv
module ball_control (
	input  logic clk,
	input  logic resetn,
	input  logic step,
	input  logic probe_done,
	output logic probe_h,
	output logic probe_v,
	output logic do_move,
	output logic step_done
);
	import breakout_pkg::*;

	ball_state_t state;
	ball_state_t state_nx;

	// one pass per frame step
	// horizontal probe, vertical probe, then the move
	always_comb begin
		state_nx = state;
		case (state)
			st_idle: begin
				// steps while busy fall through here unseen
				if (step)
					state_nx = st_probe_h;
			end
			st_probe_h:
				state_nx = st_wait_h;
			st_wait_h: begin
				if (probe_done)
					state_nx = st_probe_v;
			end
			st_probe_v:
				state_nx = st_wait_v;
			st_wait_v: begin
				if (probe_done)
					state_nx = st_move;
			end
			st_move:
				state_nx = st_idle;
			default:
				state_nx = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= st_idle;
			step_done <= 1'b0;
		end else begin
			state <= state_nx;
			// high while the new position is visible
			step_done <= (state == st_move);
		end
	end

	// probe states last one cycle so these are pulses
	assign probe_h = (state == st_probe_h);
	assign probe_v = (state == st_probe_v);
	assign do_move = (state == st_move);

endmodule

// File: brick_arbiter.sv
module brick_arbiter #(
	parameter int unsigned queue_depth = 2
) (
	input  logic                     clk,
	input  logic                     resetn,
	// ball side
	input  logic                     ball_req_valid,
	input  logic                     ball_req_write,
	input  breakout_pkg::cell_addr_t ball_req_addr,
	input  breakout_pkg::hp_t        ball_req_hp,
	output logic                     ball_credit,
	output logic                     ball_rsp_valid,
	output breakout_pkg::hp_t        ball_rsp_hp,
	// host side
	input  logic                     host_req_valid,
	input  logic                     host_req_write,
	input  breakout_pkg::cell_addr_t host_req_addr,
	input  breakout_pkg::hp_t        host_req_hp,
	output logic                     host_credit,
	output logic                     host_rsp_valid,
	output breakout_pkg::hp_t        host_rsp_hp,
	// brick memory
	output logic                     mem_en,
	output logic                     mem_write,
	output breakout_pkg::cell_addr_t mem_addr,
	output breakout_pkg::hp_t        mem_wdata,
	input  breakout_pkg::hp_t        mem_rdata,
	input  logic                     mem_ready
);
	import breakout_pkg::*;

	localparam int unsigned ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int unsigned cnt_w = $clog2(queue_depth + 1);

	// queue storage, first index is the port id
	logic       q_write [2][queue_depth];
	cell_addr_t q_addr  [2][queue_depth];
	hp_t        q_hp    [2][queue_depth];

	logic [ptr_w-1:0] wr_ptr [2];
	logic [ptr_w-1:0] rd_ptr [2];
	logic [cnt_w-1:0] q_cnt  [2];

	// incoming requests gathered by port id
	logic       in_valid [2];
	logic       in_write [2];
	cell_addr_t in_addr  [2];
	hp_t        in_hp    [2];
	logic       pop      [2];

	port_id_t rr_next;
	port_id_t winner;
	logic     grant;
	logic     rd_pend;
	port_id_t rd_port;

	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(queue_depth - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign in_valid[0] = ball_req_valid;
	assign in_write[0] = ball_req_write;
	assign in_addr[0]  = ball_req_addr;
	assign in_hp[0]    = ball_req_hp;
	assign in_valid[1] = host_req_valid;
	assign in_write[1] = host_req_write;
	assign in_addr[1]  = host_req_addr;
	assign in_hp[1]    = host_req_hp;

	// round robin, the favoured queue goes first
	always_comb begin
		grant  = 1'b0;
		winner = rr_next;
		if (mem_ready) begin
			if (q_cnt[rr_next] != '0) begin
				grant  = 1'b1;
				winner = rr_next;
			end else if (q_cnt[~rr_next] != '0) begin
				grant  = 1'b1;
				winner = ~rr_next;
			end
		end
	end

	assign pop[0] = grant && (winner == 1'b0);
	assign pop[1] = grant && (winner == 1'b1);

	// queue head straight into the memory
	assign mem_en    = grant;
	assign mem_write = q_write[winner][rd_ptr[winner]];
	assign mem_addr  = q_addr[winner][rd_ptr[winner]];
	assign mem_wdata = q_hp[winner][rd_ptr[winner]];

	// a credit returns as the entry leaves
	assign ball_credit = pop[0];
	assign host_credit = pop[1];

	// read data lands one cycle after issue
	assign ball_rsp_valid = rd_pend && (rd_port == 1'b0);
	assign host_rsp_valid = rd_pend && (rd_port == 1'b1);
	assign ball_rsp_hp    = mem_rdata;
	assign host_rsp_hp    = mem_rdata;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < 2; i++) begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				q_cnt[i]  <= '0;
			end
			rr_next <= '0;
			rd_pend <= 1'b0;
			rd_port <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (in_valid[i])
					wr_ptr[i] <= ptr_inc(wr_ptr[i]);
				if (pop[i])
					rd_ptr[i] <= ptr_inc(rd_ptr[i]);
				q_cnt[i] <= q_cnt[i] + cnt_w'(in_valid[i]) - cnt_w'(pop[i]);
			end
			// the loser gets first pick next time
			if (grant) begin
				rr_next <= ~winner;
				rd_port <= winner;
			end
			rd_pend <= grant && !mem_write;
		end
	end

	// queue payload
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (in_valid[i]) begin
				q_write[i][wr_ptr[i]] <= in_write[i];
				q_addr[i][wr_ptr[i]]  <= in_addr[i];
				q_hp[i][wr_ptr[i]]    <= in_hp[i];
			end
		end
	end

endmodule

// File: brick_map.sv
module brick_map (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    en,
	input  logic                    write,
	input  breakout_pkg::cell_addr_t addr,
	input  breakout_pkg::hp_t        wdata,
	output breakout_pkg::hp_t        rdata,
	output logic                    ready
);
	import breakout_pkg::*;

	// one entry per cell address
	localparam int unsigned num_cells = 2 ** $bits(cell_addr_t);

	hp_t        mem [num_cells];
	cell_addr_t clr_addr;

	// clear sweep, one cell per cycle after reset
	always_ff @(posedge clk) begin
		if (!resetn) begin
			clr_addr <= '0;
			ready    <= 1'b0;
		end else if (!ready) begin
			clr_addr <= clr_addr + 1'b1;
			// last cell written this cycle
			if (clr_addr == cell_addr_t'(num_cells - 1))
				ready <= 1'b1;
		end
	end

	// single port array
	// reads see the old content on a write
	always_ff @(posedge clk) begin
		if (!ready)
			mem[clr_addr] <= '0;
		else if (en && write)
			mem[addr] <= wdata;
		if (en)
			rdata <= mem[addr];
	end

endmodule

// File: breakout_pkg.sv
package breakout_pkg;

	// pixel coordinate on the playfield
	typedef logic [9:0] coord_t;

	// brick hit points
	// zero means the cell is empty
	typedef logic [1:0] hp_t;

	// brick cell index, row * 16 + column
	typedef logic [6:0] cell_addr_t;

	// requester number on the arbiter
	// 0 is the ball, 1 is the host
	typedef logic [0:0] port_id_t;

	// ball step sequencing
	typedef enum logic [2:0] {
		st_idle,
		st_probe_h,
		st_wait_h,
		st_probe_v,
		st_wait_v,
		st_move
	} ball_state_t;

endpackage
